// ==== compile.f ====
+incdir+tests
source/mac_pkg.sv
source/xsyw_mult.sv
source/cmd_rx.sv
source/result_tx.sv
source/mac_accum.sv
source/approx_mac_top.sv
tests/approx_mac_tb.sv

// ==== source/approx_mac_top.sv ====
module approx_mac_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 op_req,
    input  mac_pkg::mac_cmd_t    op_cmd,
    output logic                 op_ack,
    output logic                 res_req,
    output mac_pkg::mac_result_t res_data,
    input  logic                 res_ack
);

    import mac_pkg::*;

    logic        cmd_valid;
    mac_cmd_t    cmd;
    logic        accum_ready;
    logic        res_valid;
    mac_result_t res;
    logic        tx_busy;

    cmd_rx u_cmd_rx (
        .clk         (clk),
        .arst_n      (arst_n),
        .op_req      (op_req),
        .op_cmd      (op_cmd),
        .op_ack      (op_ack),
        .accum_ready (accum_ready),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd)
    );

    mac_accum u_mac_accum (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .accum_ready (accum_ready),
        .res_valid   (res_valid),
        .res         (res),
        .tx_busy     (tx_busy)
    );

    result_tx u_result_tx (
        .clk       (clk),
        .arst_n    (arst_n),
        .res_valid (res_valid),
        .res       (res),
        .tx_busy   (tx_busy),
        .res_req   (res_req),
        .res_data  (res_data),
        .res_ack   (res_ack)
    );

endmodule

// ==== source/cmd_rx.sv ====
module cmd_rx (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              op_req,
    input  mac_pkg::mac_cmd_t op_cmd,
    output logic              op_ack,
    input  logic              accum_ready,
    output logic              cmd_valid,
    output mac_pkg::mac_cmd_t cmd
);

    import mac_pkg::*;

    logic accept;

    // A new request is taken only when the previous handshake has closed
    // and the accumulator can take another term.
    assign accept = op_req && !op_ack && accum_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_ack    <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= accept;
            if (accept) begin
                op_ack <= 1'b1;
            end else if (op_ack && !op_req) begin
                op_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd <= op_cmd;
        end
    end

endmodule

// ==== source/mac_accum.sv ====
module mac_accum (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cmd_valid,
    input  mac_pkg::mac_cmd_t    cmd,
    output logic                 accum_ready,
    output logic                 res_valid,
    output mac_pkg::mac_result_t res,
    input  logic                 tx_busy
);

    import mac_pkg::*;

    product_t                mult_z;
    product_t                prod;
    logic                    p_valid;
    logic                    p_last;
    logic signed [ACC_W-1:0] sum;
    logic [CNT_W-1:0]        count;
    logic signed [ACC_W-1:0] sum_next;
    logic [CNT_W-1:0]        count_next;

    xsyw_mult u_mult (
        .x (cmd.x),
        .y (cmd.y),
        .z (mult_z)
    );

    // Product stage.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p_valid <= 1'b0;
            p_last  <= 1'b0;
        end else begin
            p_valid <= cmd_valid;
            p_last  <= cmd_valid && cmd.last;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            prod <= mult_z;
        end
    end

    assign sum_next   = sum + {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
    assign count_next = count + 1'b1;

    // Accumulate stage. A last term hands the totals over and restarts at zero.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum       <= '0;
            count     <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= p_valid && p_last;
            if (p_valid) begin
                if (p_last) begin
                    sum   <= '0;
                    count <= '0;
                end else begin
                    sum   <= sum_next;
                    count <= count_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (p_valid && p_last) begin
            res.sum   <= sum_next;
            res.count <= count_next;
        end
    end

    // Hold off new terms while a batch is finishing or its result is still out.
    assign accum_ready = !(cmd_valid && cmd.last) && !(p_valid && p_last) && !tx_busy;

endmodule

// ==== source/mac_pkg.sv ====
package mac_pkg;

    // Operand and product widths of the approximate multiplier.
    localparam int OP_W   = 16;
    localparam int PROD_W = 2 * OP_W;

    // Accumulator width, with headroom above the 32-bit product.
    localparam int ACC_W  = 40;

    // Term counter width. The counter wraps.
    localparam int CNT_W  = 16;

    typedef logic signed [OP_W-1:0]   operand_t;
    typedef logic signed [PROD_W-1:0] product_t;

    // One multiply-accumulate term as sent by the host.
    typedef struct packed {
        operand_t x;
        operand_t y;
        logic     last;
    } mac_cmd_t;

    // Finished batch, returned to the host.
    typedef struct packed {
        logic signed [ACC_W-1:0] sum;
        logic [CNT_W-1:0]        count;
    } mac_result_t;

endpackage

// ==== source/result_tx.sv ====
module result_tx (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 res_valid,
    input  mac_pkg::mac_result_t res,
    output logic                 tx_busy,
    output logic                 res_req,
    output mac_pkg::mac_result_t res_data,
    input  logic                 res_ack
);

    import mac_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_WAIT_LOW
    } tx_state_t;

    tx_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE:     if (res_valid) state <= TX_REQ;
                TX_REQ:      if (res_ack) state <= TX_WAIT_LOW;
                TX_WAIT_LOW: if (!res_ack) state <= TX_IDLE;
                default:     state <= TX_IDLE;
            endcase
        end
    end

    // Result stays put until the next batch, so it covers the whole handshake.
    always_ff @(posedge clk) begin
        if (res_valid && state == TX_IDLE) begin
            res_data <= res;
        end
    end

    assign res_req = (state == TX_REQ);
    assign tx_busy = res_valid || (state != TX_IDLE);

endmodule

// ==== source/xsyw_mult.sv ====
module xsyw_mult (
    input  mac_pkg::operand_t x,
    input  mac_pkg::operand_t y,
    output mac_pkg::product_t z
);

    import mac_pkg::*;

    // Baugh-Wooley rows, one per bit of x, each 16 bits wide before shifting.
    logic [OP_W-1:0]   pp [OP_W];
    // Sparse correction vectors that stand in for the rows of x bits 0 to 5.
    logic [20:0]       corr [4];
    logic [PROD_W-1:0] acc;

    always_comb begin
        for (int i = 0; i < OP_W - 1; i++) begin
            pp[i][OP_W-2:0] = y[OP_W-2:0] & {(OP_W-1){x[i]}};
            pp[i][OP_W-1]   = ~(y[OP_W-1] & x[i]);
        end
        // The sign row is inverted except for its own sign column.
        pp[OP_W-1][OP_W-2:0] = ~(y[OP_W-2:0] & {(OP_W-1){x[OP_W-1]}});
        pp[OP_W-1][OP_W-1]   = y[OP_W-1] & x[OP_W-1];
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            corr[k] = '0;
        end

        corr[0][4]  = pp[0][3] & pp[1][2];
        corr[0][7]  = pp[4][2] & pp[5][1];
        corr[0][8]  = pp[4][4] ^ pp[5][3];
        corr[0][9]  = pp[0][9] ^ pp[1][8];
        corr[0][10] = pp[0][9] & pp[1][8];
        corr[0][11] = pp[2][9] ^ pp[3][8];
        corr[0][13] = pp[0][12] & pp[1][11];
        corr[0][15] = pp[0][14] & pp[1][13];
        corr[0][16] = pp[4][11] & pp[5][10];
        corr[0][17] = pp[1][15];
        corr[0][18] = pp[2][15] & pp[3][14];
        corr[0][19] = pp[4][14] & pp[5][13];
        corr[0][20] = pp[4][15] & pp[5][14];

        corr[1][4]  = pp[2][1] & pp[3][0];
        corr[1][13] = pp[0][13] ^ pp[1][12];
        corr[1][15] = pp[2][12] & pp[3][11];
        corr[1][16] = pp[4][12] ^ pp[5][11];
        corr[1][17] = pp[2][14] | pp[3][13];
        corr[1][18] = pp[3][15];
        corr[1][19] = pp[4][15] ^ pp[5][14];
        corr[1][20] = pp[5][15];

        corr[2][13] = pp[2][10] & pp[3][9];
        corr[2][15] = pp[2][13] ^ pp[3][12];
        corr[2][17] = pp[2][15] ^ pp[3][14];
        corr[2][18] = pp[4][14] | pp[5][13];

        corr[3][18] = pp[4][14] ^ pp[5][13];
    end

    always_comb begin
        // Baugh-Wooley constant ones at bits 16 and 31.
        acc = (PROD_W'(1) << OP_W) + (PROD_W'(1) << (PROD_W - 1));

        // Exact rows for x bits 6 to 15.
        for (int i = 6; i < OP_W; i++) begin
            acc = acc + (PROD_W'(pp[i]) << i);
        end

        for (int k = 0; k < 4; k++) begin
            acc = acc + PROD_W'(corr[k]);
        end
    end

    // The sum wraps at 32 bits and is read as two's complement.
    assign z = acc;

endmodule

// ==== tests/xsyw_model.svh ====
`ifndef XSYW_MODEL_SVH
`define XSYW_MODEL_SVH

// One Baugh-Wooley partial-product bit x[i] & y[j]. A bit that pairs a sign
// bit with a magnitude bit is inverted.
function automatic logic bw_bit(input mac_pkg::operand_t a, input mac_pkg::operand_t b,
                                input int i, input int j);
    logic pair;
    pair = a[i] & b[j];
    if ((i == 15) != (j == 15)) begin
        pair = ~pair;
    end
    return pair;
endfunction

// Weight of a single bit placed at column pos of the 32-bit product.
function automatic logic [31:0] weigh(input logic b, input int pos);
    return {31'b0, b} << pos;
endfunction

// Approximate signed product. Rows for a bits 6 to 15 are exact. The low rows
// are replaced by a flat list of compressed terms, each added at its column.
function automatic mac_pkg::product_t approx_product(input mac_pkg::operand_t a,
                                                     input mac_pkg::operand_t b);
    logic [31:0] acc;
    acc = 32'h8001_0000;
    for (int i = 6; i < 16; i++) begin
        for (int j = 0; j < 16; j++) begin
            acc = acc + weigh(bw_bit(a, b, i, j), i + j);
        end
    end
    acc = acc + weigh(bw_bit(a, b, 0, 3) & bw_bit(a, b, 1, 2), 4);
    acc = acc + weigh(bw_bit(a, b, 2, 1) & bw_bit(a, b, 3, 0), 4);
    acc = acc + weigh(bw_bit(a, b, 4, 2) & bw_bit(a, b, 5, 1), 7);
    acc = acc + weigh(bw_bit(a, b, 4, 4) ^ bw_bit(a, b, 5, 3), 8);
    acc = acc + weigh(bw_bit(a, b, 0, 9) ^ bw_bit(a, b, 1, 8), 9);
    acc = acc + weigh(bw_bit(a, b, 0, 9) & bw_bit(a, b, 1, 8), 10);
    acc = acc + weigh(bw_bit(a, b, 2, 9) ^ bw_bit(a, b, 3, 8), 11);
    acc = acc + weigh(bw_bit(a, b, 0, 12) & bw_bit(a, b, 1, 11), 13);
    acc = acc + weigh(bw_bit(a, b, 0, 13) ^ bw_bit(a, b, 1, 12), 13);
    acc = acc + weigh(bw_bit(a, b, 2, 10) & bw_bit(a, b, 3, 9), 13);
    acc = acc + weigh(bw_bit(a, b, 0, 14) & bw_bit(a, b, 1, 13), 15);
    acc = acc + weigh(bw_bit(a, b, 2, 12) & bw_bit(a, b, 3, 11), 15);
    acc = acc + weigh(bw_bit(a, b, 2, 13) ^ bw_bit(a, b, 3, 12), 15);
    acc = acc + weigh(bw_bit(a, b, 4, 11) & bw_bit(a, b, 5, 10), 16);
    acc = acc + weigh(bw_bit(a, b, 4, 12) ^ bw_bit(a, b, 5, 11), 16);
    acc = acc + weigh(bw_bit(a, b, 1, 15), 17);
    acc = acc + weigh(bw_bit(a, b, 2, 14) | bw_bit(a, b, 3, 13), 17);
    acc = acc + weigh(bw_bit(a, b, 2, 15) ^ bw_bit(a, b, 3, 14), 17);
    acc = acc + weigh(bw_bit(a, b, 2, 15) & bw_bit(a, b, 3, 14), 18);
    acc = acc + weigh(bw_bit(a, b, 3, 15), 18);
    acc = acc + weigh(bw_bit(a, b, 4, 14) | bw_bit(a, b, 5, 13), 18);
    acc = acc + weigh(bw_bit(a, b, 4, 14) ^ bw_bit(a, b, 5, 13), 18);
    acc = acc + weigh(bw_bit(a, b, 4, 14) & bw_bit(a, b, 5, 13), 19);
    acc = acc + weigh(bw_bit(a, b, 4, 15) ^ bw_bit(a, b, 5, 14), 19);
    acc = acc + weigh(bw_bit(a, b, 4, 15) & bw_bit(a, b, 5, 14), 20);
    acc = acc + weigh(bw_bit(a, b, 5, 15), 20);
    return acc;
endfunction

`endif

// ==== tests/approx_mac_tb.sv ====
module approx_mac_tb;

    import mac_pkg::*;

    `include "xsyw_model.svh"

    localparam int MAX_CYCLES = 60000;

    logic        clk;
    logic        arst_n;
    logic        op_req;
    mac_cmd_t    op_cmd;
    logic        op_ack;
    logic        res_req;
    mac_result_t res_data;
    logic        res_ack;

    mac_result_t expected_q[$];
    operand_t    bx[8];
    operand_t    by[8];
    integer      seed = 32'h78ee;
    int          cycles = 0;
    int          batches_sent = 0;
    int          results_seen = 0;
    int          max_ack_delay = 0;

    approx_mac_top approx_mac_top_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_req   (op_req),
        .op_cmd   (op_cmd),
        .op_ack   (op_ack),
        .res_req  (res_req),
        .res_data (res_data),
        .res_ack  (res_ack)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    function automatic operand_t random_operand();
        integer r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic int pick_below(input int n);
        integer r;
        r = $random(seed);
        return $unsigned(r) % n;
    endfunction

    // One four-phase transfer on the command port.
    task automatic send_cmd(input operand_t x, input operand_t y, input logic last);
        @(negedge clk);
        op_cmd.x    = x;
        op_cmd.y    = y;
        op_cmd.last = last;
        op_req      = 1'b1;
        do @(negedge clk); while (!op_ack);
        op_req = 1'b0;
        do @(negedge clk); while (op_ack);
    endtask

    // Sends bx/by[0 .. len-1] as one batch and queues the result it should give.
    task automatic run_batch(input int len);
        logic signed [ACC_W-1:0] total;
        product_t                p;
        mac_result_t             exp;
        total = '0;
        for (int i = 0; i < len; i++) begin
            p     = approx_product(bx[i], by[i]);
            total = total + {{(ACC_W - 32){p[31]}}, p};
        end
        exp.sum   = total;
        exp.count = len[CNT_W-1:0];
        expected_q.push_back(exp);
        batches_sent++;
        for (int i = 0; i < len; i++) begin
            send_cmd(bx[i], by[i], i == len - 1);
        end
    endtask

    // Host side of the result port. Each new request is compared in order.
    initial begin : compare
        mac_result_t exp;
        int          delay;
        forever begin
            @(negedge clk);
            if (res_req && !res_ack) begin
                if (expected_q.size() == 0) begin
                    $display("A result arrived while no batch was outstanding");
                    $display("Some tests failed");
                    $fatal(1);
                end
                exp = expected_q.pop_front();
                check_equal(64'(res_data.sum), 64'(exp.sum), "batch sum");
                check_equal(64'(res_data.count), 64'(exp.count), "batch term count");
                results_seen++;
                delay = (max_ack_delay == 0) ? 0 : pick_below(max_ack_delay + 1);
                repeat (delay) @(negedge clk);
                res_ack = 1'b1;
                do @(negedge clk); while (res_req);
                res_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        operand_t corners[5];
        int       len;
        corners[0] = 16'sh8000;
        corners[1] = 16'sh7fff;
        corners[2] = 16'shffff;
        corners[3] = 16'sh0000;
        corners[4] = 16'sh0001;
        clk     = 1'b0;
        arst_n  = 1'b0;
        op_req  = 1'b0;
        op_cmd  = '0;
        res_ack = 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_equal(64'(op_ack), 64'd0, "op_ack during reset");
            check_equal(64'(res_req), 64'd0, "res_req during reset");
        end
        arst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_equal(64'(op_ack), 64'd0, "op_ack after reset");
            check_equal(64'(res_req), 64'd0, "res_req after reset");
        end

        for (int n = 0; n < 40; n++) begin
            bx[0] = random_operand();
            by[0] = random_operand();
            run_batch(1);
        end

        for (int a = 0; a < 5; a++) begin
            for (int b = 0; b < 5; b++) begin
                bx[0] = corners[a];
                by[0] = corners[b];
                run_batch(1);
            end
        end

        for (int n = 0; n < 60; n++) begin
            len = 1 + pick_below(8);
            for (int i = 0; i < len; i++) begin
                bx[i] = random_operand();
                by[i] = random_operand();
            end
            run_batch(len);
        end

        // The host is now slow to acknowledge results while commands keep coming.
        max_ack_delay = 12;
        for (int n = 0; n < 60; n++) begin
            len = 1 + pick_below(8);
            for (int i = 0; i < len; i++) begin
                bx[i] = random_operand();
                by[i] = random_operand();
            end
            run_batch(len);
        end

        // Identical batches back to back must give identical results.
        for (int n = 0; n < 10; n++) begin
            len = 1 + pick_below(8);
            for (int i = 0; i < len; i++) begin
                bx[i] = random_operand();
                by[i] = random_operand();
            end
            run_batch(len);
            run_batch(len);
        end

        while (results_seen < batches_sent) @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule
